// File: hw/act_pkg.sv
package act_pkg;

    localparam int data_w = 16;

    // segment and table counts
    localparam int sig_segments   = 15;
    localparam int sig_bounds     = sig_segments - 1;
    localparam int exp_frac_steps = 9;
    localparam int exp_int_min    = -2;
    localparam int exp_int_steps  = 4;

    // fixed point sample, coefficient or result
    typedef logic signed [data_w-1:0]   data_t;
    typedef logic signed [2*data_w-1:0] prod_t;

    typedef logic [3:0] seg_idx_t;
    typedef logic [1:0] exp_int_idx_t;
    typedef logic [3:0] exp_frac_idx_t;

    typedef enum logic {
        ACT_SIGMOID = 1'b0,
        ACT_EXP     = 1'b1
    } act_func_e;

    typedef struct packed {
        data_t alpha;
        data_t bias;
        data_t x;
    } sig_coef_t;

    typedef struct packed {
        data_t int_exp;
        data_t frac_exp;
    } exp_factor_t;

    // scale a non-negative real by 2^frac_bits and round to nearest
    function automatic data_t to_fixed(real r, int frac_bits);
        return data_t'($rtoi(r * $itor(1 << frac_bits) + 0.5));
    endfunction

    // upper bound of segment i in half units
    function automatic data_t sig_thresholds(int i, int frac_bits);
        int halves;
        case (i)
            0:       halves = -16;
            1:       halves = -9;
            2:       halves = -6;
            3:       halves = -5;
            4:       halves = -4;
            5:       halves = -3;
            6:       halves = -2;
            7:       halves = 2;
            8:       halves = 3;
            9:       halves = 4;
            10:      halves = 5;
            11:      halves = 6;
            12:      halves = 9;
            13:      halves = 16;
            default: halves = 0;
        endcase
        return data_t'(halves * (1 << (frac_bits - 1)));
    endfunction

    // slopes are mirrored around the middle segment
    function automatic data_t sig_alpha(int seg, int frac_bits);
        real a;
        case (seg)
            1, 13:   a = 0.00247;
            2, 12:   a = 0.02415;
            3, 11:   a = 0.0639;
            4, 10:   a = 0.0831;
            5, 9:    a = 0.12891;
            6, 8:    a = 0.16351;
            7:       a = 0.23674;
            default: a = 0.0;
        endcase
        return to_fixed(a, frac_bits);
    endfunction

    function automatic data_t sig_bias(int seg, int frac_bits);
        real b;
        case (seg)
            1:       b = 0.01843;
            2:       b = 0.11599;
            3:       b = 0.23525;
            4:       b = 0.28325;
            5:       b = 0.37487;
            6:       b = 0.42677;
            7:       b = 0.5;
            8:       b = 0.57323;
            9:       b = 0.62513;
            10:      b = 0.71675;
            11:      b = 0.76475;
            12:      b = 0.88401;
            13:      b = 0.98157;
            14:      b = 1.0;
            default: b = 0.0;
        endcase
        return to_fixed(b, frac_bits);
    endfunction

    // e^n for n from exp_int_min upwards
    function automatic data_t exp_int_value(int n, int frac_bits);
        real e;
        case (n)
            -2:      e = 0.1353352832;
            -1:      e = 0.3678794412;
            0:       e = 1.0;
            1:       e = 2.7182818285;
            default: e = 0.0;
        endcase
        return to_fixed(e, frac_bits);
    endfunction

    // e^(k/8)
    function automatic data_t exp_frac_value(int k, int frac_bits);
        real e;
        case (k)
            0:       e = 1.0;
            1:       e = 1.1331484531;
            2:       e = 1.2840254167;
            3:       e = 1.4549914146;
            4:       e = 1.6487212707;
            5:       e = 1.8682459574;
            6:       e = 2.1170000166;
            7:       e = 2.3988752939;
            8:       e = 2.7182818285;
            default: e = 0.0;
        endcase
        return to_fixed(e, frac_bits);
    endfunction

endpackage

// File: hw/sigmoid_segment_lut.sv
`timescale 1ns/10ps

module sigmoid_segment_lut #(
    parameter int frac_bits = 11
) (
    input  logic               M_AXI_ACLK,
    input  logic               rst,
    input  act_pkg::data_t     x,
    output act_pkg::sig_coef_t coef
);

    act_pkg::data_t    bound [act_pkg::sig_bounds];
    act_pkg::data_t    alpha_tab [act_pkg::sig_segments];
    act_pkg::data_t    bias_tab [act_pkg::sig_segments];
    act_pkg::seg_idx_t seg;

    // segment bounds are fixed at elaboration
    for (genvar g = 0; g < act_pkg::sig_bounds; g++) begin : g_bound
        localparam act_pkg::data_t bound_value = act_pkg::sig_thresholds(g, frac_bits);

        assign bound[g] = bound_value;
    end

    for (genvar g = 0; g < act_pkg::sig_segments; g++) begin : g_coef
        localparam act_pkg::data_t alpha_value = act_pkg::sig_alpha(g, frac_bits);
        localparam act_pkg::data_t bias_value  = act_pkg::sig_bias(g, frac_bits);

        assign alpha_tab[g] = alpha_value;
        assign bias_tab[g]  = bias_value;
    end

    // segment index is the number of bounds strictly below x
    always_comb begin
        seg = '0;
        for (int i = 0; i < act_pkg::sig_bounds; i++) begin
            if (x > bound[i]) begin
                seg = seg + act_pkg::seg_idx_t'(1);
            end
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (rst) begin
            coef <= '0;
        end else begin
            coef.alpha <= alpha_tab[seg];
            coef.bias  <= bias_tab[seg];
            // sample rides along for the multiply
            coef.x     <= x;
        end
    end

    seg_range_a: assert property (
        @(posedge M_AXI_ACLK) disable iff (rst)
        seg < act_pkg::seg_idx_t'(act_pkg::sig_segments)
    );

endmodule

// File: hw/exp_split_lut.sv
`timescale 1ns/10ps

module exp_split_lut #(
    parameter int frac_bits = 11
) (
    input  logic                 M_AXI_ACLK,
    input  logic                 rst,
    input  act_pkg::data_t       x,
    output act_pkg::exp_factor_t factors
);

    // clamp window is -2 up to 2 minus one lsb
    localparam act_pkg::data_t x_min =
        act_pkg::data_t'(act_pkg::exp_int_min * (1 << frac_bits));
    localparam act_pkg::data_t x_max =
        act_pkg::data_t'((act_pkg::exp_int_min + act_pkg::exp_int_steps) * (1 << frac_bits) - 1);
    localparam act_pkg::data_t half_step = act_pkg::data_t'(1 << (frac_bits - 4));

    act_pkg::data_t         int_tab [act_pkg::exp_int_steps];
    act_pkg::data_t         frac_tab [act_pkg::exp_frac_steps];
    act_pkg::data_t         xc;
    act_pkg::data_t         n;
    act_pkg::data_t         f;
    act_pkg::data_t         int_ofs;
    act_pkg::data_t         frac_ofs;
    act_pkg::exp_int_idx_t  int_idx;
    act_pkg::exp_frac_idx_t frac_idx;

    for (genvar g = 0; g < act_pkg::exp_int_steps; g++) begin : g_int
        localparam act_pkg::data_t int_value =
            act_pkg::exp_int_value(g + act_pkg::exp_int_min, frac_bits);

        assign int_tab[g] = int_value;
    end

    for (genvar g = 0; g < act_pkg::exp_frac_steps; g++) begin : g_frac
        localparam act_pkg::data_t frac_value = act_pkg::exp_frac_value(g, frac_bits);

        assign frac_tab[g] = frac_value;
    end

    always_comb begin
        if (x < x_min) begin
            xc = x_min;
        end else if (x > x_max) begin
            xc = x_max;
        end else begin
            xc = x;
        end
        // floor and then the non-negative remainder
        n        = xc >>> frac_bits;
        f        = xc - (n <<< frac_bits);
        int_ofs  = n - act_pkg::data_t'(act_pkg::exp_int_min);
        // rounding to the nearest eighth can reach k = 8
        frac_ofs = (f + half_step) >>> (frac_bits - 3);
    end

    assign int_idx  = act_pkg::exp_int_idx_t'(int_ofs);
    assign frac_idx = act_pkg::exp_frac_idx_t'(frac_ofs);

    always_ff @(posedge M_AXI_ACLK) begin
        if (rst) begin
            factors <= '0;
        end else begin
            factors.int_exp  <= int_tab[int_idx];
            factors.frac_exp <= frac_tab[frac_idx];
        end
    end

    int_idx_a: assert property (
        @(posedge M_AXI_ACLK) disable iff (rst)
        int_ofs >= 0 && int_ofs < act_pkg::data_t'(act_pkg::exp_int_steps)
    );

    frac_idx_a: assert property (
        @(posedge M_AXI_ACLK) disable iff (rst)
        frac_ofs >= 0 && frac_ofs < act_pkg::data_t'(act_pkg::exp_frac_steps)
    );

endmodule

// File: hw/act_combine.sv
`timescale 1ns/10ps

module act_combine #(
    parameter int frac_bits = 11
) (
    input  logic                 M_AXI_ACLK,
    input  logic                 rst,
    input  act_pkg::act_func_e   func,
    input  act_pkg::sig_coef_t   coef,
    input  act_pkg::exp_factor_t factors,
    output act_pkg::data_t       y
);

    act_pkg::act_func_e func_d;
    act_pkg::prod_t     prod;
    act_pkg::data_t     term;
    act_pkg::data_t     offset;
    act_pkg::data_t     term_q;
    act_pkg::data_t     offset_q;

    // func lines up with the lookup registers
    always_ff @(posedge M_AXI_ACLK) begin
        if (rst) begin
            func_d <= act_pkg::ACT_SIGMOID;
        end else begin
            func_d <= func;
        end
    end

    always_comb begin
        if (func_d == act_pkg::ACT_EXP) begin
            prod   = factors.int_exp * factors.frac_exp;
            offset = '0;
        end else begin
            prod   = coef.alpha * coef.x;
            offset = coef.bias;
        end
        // back to frac_bits fractional bits
        term = act_pkg::data_t'(prod >>> frac_bits);
    end

    // stage one holds the scaled product and pending offset
    always_ff @(posedge M_AXI_ACLK) begin
        if (rst) begin
            term_q   <= '0;
            offset_q <= '0;
        end else begin
            term_q   <= term;
            offset_q <= offset;
        end
    end

    // stage two
    always_ff @(posedge M_AXI_ACLK) begin
        if (rst) begin
            y <= '0;
        end else begin
            y <= term_q + offset_q;
        end
    end

    func_known_a: assert property (
        @(posedge M_AXI_ACLK) disable iff (rst)
        !$isunknown(func_d) && func_d inside {act_pkg::ACT_SIGMOID, act_pkg::ACT_EXP}
    );

endmodule

// File: hw/activation_unit.sv
`timescale 1ns/10ps

module activation_unit #(
    parameter int frac_bits = 11
) (
    input  logic               M_AXI_ACLK,
    input  logic               rst,
    input  act_pkg::data_t     x,
    input  act_pkg::act_func_e func,
    output act_pkg::data_t     y
);

    act_pkg::sig_coef_t   coef;
    act_pkg::exp_factor_t factors;

    // both lookups see every sample
    sigmoid_segment_lut #(
        .frac_bits(frac_bits)
    ) sig_lut_i (
        .M_AXI_ACLK(M_AXI_ACLK),
        .rst       (rst),
        .x         (x),
        .coef      (coef)
    );

    exp_split_lut #(
        .frac_bits(frac_bits)
    ) exp_lut_i (
        .M_AXI_ACLK(M_AXI_ACLK),
        .rst       (rst),
        .x         (x),
        .factors   (factors)
    );

    act_combine #(
        .frac_bits(frac_bits)
    ) combine_i (
        .M_AXI_ACLK(M_AXI_ACLK),
        .rst       (rst),
        .func      (func),
        .coef      (coef),
        .factors   (factors),
        .y         (y)
    );

endmodule

// File: bench/act_model.svh
`ifndef ACT_MODEL_SVH
`define ACT_MODEL_SVH

// galois lfsr state for x^16 + x^14 + x^13 + x^11 + 1
logic [15:0] lfsr_state = 16'd29329;

// one step gives one bit
function automatic logic lfsr_step();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
        lfsr_state = lfsr_state ^ 16'hB400;
    end
    return out;
endfunction

function automatic logic [15:0] random_bits(int count);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < count; i++) begin
        r = {r[14:0], lfsr_step()};
    end
    return r;
endfunction

// lowest segment whose upper bound is at or above v or else the top one
function automatic act_pkg::data_t model_sigmoid(act_pkg::data_t v, int fb);
    int     seg;
    longint acc;
    seg = act_pkg::sig_segments - 1;
    for (int i = act_pkg::sig_segments - 2; i >= 0; i--) begin
        if (v <= act_pkg::sig_thresholds(i, fb)) begin
            seg = i;
        end
    end
    acc = longint'(act_pkg::sig_alpha(seg, fb)) * longint'(v);
    acc = (acc >>> fb) + longint'(act_pkg::sig_bias(seg, fb));
    return act_pkg::data_t'(acc);
endfunction

function automatic act_pkg::data_t model_exp(act_pkg::data_t v, int fb);
    longint lo;
    longint hi;
    longint xc;
    longint n;
    longint k;
    longint p;
    lo = longint'(act_pkg::exp_int_min) * (longint'(1) << fb);
    hi = (longint'(2) << fb) - 1;
    xc = v;
    if (xc < lo) begin
        xc = lo;
    end else if (xc > hi) begin
        xc = hi;
    end
    n = xc >>> fb;
    // fraction rounded to the nearest eighth
    k = ((xc - (n << fb)) + (longint'(1) << (fb - 4))) >>> (fb - 3);
    p = longint'(act_pkg::exp_int_value(int'(n), fb))
        * longint'(act_pkg::exp_frac_value(int'(k), fb));
    return act_pkg::data_t'(p >>> fb);
endfunction

`endif

// File: bench/tb_activation_unit.sv
`timescale 1ns/10ps

module tb_activation_unit;

    localparam int frac_bits      = 11;
    localparam int random_count   = 400;
    localparam int timeout_cycles = 2 * (random_count + 100);
    localparam logic [1:0] sat_none = 2'd0;
    localparam logic [1:0] sat_low  = 2'd1;
    localparam logic [1:0] sat_high = 2'd2;

    logic               M_AXI_ACLK = 1'b0;
    logic               rst;
    act_pkg::data_t     x;
    act_pkg::act_func_e func;
    act_pkg::data_t     y;
    logic [1:0]         sat_tag;

    act_pkg::data_t expect_q [3];
    logic [1:0]     sat_q [3];
    logic           rst_d = 1'b0;
    int             cycle = 0;
    int             errors = 0;
    int             test_base = 0;
    int             tests = 0;
    int             failed = 0;

    `include "act_model.svh"

    activation_unit #(
        .frac_bits(frac_bits)
    ) dut_i (
        .M_AXI_ACLK(M_AXI_ACLK),
        .rst       (rst),
        .x         (x),
        .func      (func),
        .y         (y)
    );

    always #2 M_AXI_ACLK = ~M_AXI_ACLK;

    // expected results travel the same three stages as the DUT
    always @(posedge M_AXI_ACLK) begin
        cycle <= cycle + 1;
        rst_d <= rst;
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                expect_q[i] <= '0;
                sat_q[i]    <= sat_none;
            end
        end else begin
            if (func == act_pkg::ACT_EXP) begin
                expect_q[0] <= model_exp(x, frac_bits);
            end else begin
                expect_q[0] <= model_sigmoid(x, frac_bits);
            end
            expect_q[1] <= expect_q[0];
            expect_q[2] <= expect_q[1];
            sat_q[0]    <= sat_tag;
            sat_q[1]    <= sat_q[0];
            sat_q[2]    <= sat_q[1];
        end
    end

    reset_zero_a: assert property (@(posedge M_AXI_ACLK) disable iff (cycle == 0)
        (rst || rst_d) |-> y == '0)
        else begin
            errors++;
            $display("Mismatch y in reset: got %h, expected %h", $sampled(y), 16'h0);
        end

    result_a: assert property (@(posedge M_AXI_ACLK) disable iff (cycle == 0)
        y == expect_q[2])
        else begin
            errors++;
            $display("Mismatch y: got %h, expected %h", $sampled(y), $sampled(expect_q[2]));
        end

    sat_low_a: assert property (@(posedge M_AXI_ACLK) disable iff (cycle == 0)
        sat_q[2] == sat_low |-> y == '0)
        else begin
            errors++;
            $display("Mismatch y at low saturation: got %h, expected %h", $sampled(y), 16'h0);
        end

    sat_high_a: assert property (@(posedge M_AXI_ACLK) disable iff (cycle == 0)
        sat_q[2] == sat_high |-> y == act_pkg::data_t'(1 << frac_bits))
        else begin
            errors++;
            $display("Mismatch y at high saturation: got %h, expected %h",
                     $sampled(y), act_pkg::data_t'(1 << frac_bits));
        end

    task automatic drive_sample(input int v, input act_pkg::act_func_e f,
                                input logic [1:0] tag = sat_none);
        @(negedge M_AXI_ACLK);
        x       = act_pkg::data_t'(v);
        func    = f;
        sat_tag = tag;
    endtask

    // lets the last sample reach y before counting
    task automatic close_test(input string name);
        int errs;
        repeat (4) @(posedge M_AXI_ACLK);
        @(negedge M_AXI_ACLK);
        errs = errors - test_base;
        tests++;
        if (errs == 0) begin
            $display("test %-12s ok", name);
        end else begin
            failed++;
            $display("test %-12s %0d errors", name, errs);
        end
        test_base = errors;
    endtask

    initial begin : watchdog
        wait (cycle >= timeout_cycles);
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int one;
        int b;
        int b_prev;
        one     = 1 << frac_bits;
        rst     = 1'b1;
        x       = '0;
        func    = act_pkg::ACT_SIGMOID;
        sat_tag = sat_none;
        repeat (2) @(posedge M_AXI_ACLK);
        @(negedge M_AXI_ACLK);
        rst = 1'b0;
        repeat (3) drive_sample(0, act_pkg::ACT_SIGMOID);
        close_test("reset");

        // every bound, one lsb above it, and the segment midpoints
        for (int i = 0; i < act_pkg::sig_segments - 1; i++) begin
            b = act_pkg::sig_thresholds(i, frac_bits);
            drive_sample(b, act_pkg::ACT_SIGMOID);
            drive_sample(b + 1, act_pkg::ACT_SIGMOID);
            if (i > 0) begin
                drive_sample((b_prev + b) / 2, act_pkg::ACT_SIGMOID);
            end
            b_prev = b;
        end
        close_test("sig_sweep");

        drive_sample(-32768, act_pkg::ACT_SIGMOID, sat_low);
        drive_sample(-8 * one, act_pkg::ACT_SIGMOID, sat_low);
        drive_sample(8 * one + 1, act_pkg::ACT_SIGMOID, sat_high);
        drive_sample(12 * one, act_pkg::ACT_SIGMOID, sat_high);
        drive_sample(32767, act_pkg::ACT_SIGMOID, sat_high);
        close_test("sig_sat");

        // rounding midpoints where k = 7 rounds up to 8
        for (int n = act_pkg::exp_int_min; n < 2; n++) begin
            for (int k = 0; k < 8; k++) begin
                drive_sample(n * one + k * (one / 8) + one / 16, act_pkg::ACT_EXP);
            end
        end
        drive_sample(-32768, act_pkg::ACT_EXP);
        drive_sample(-2 * one - 1, act_pkg::ACT_EXP);
        drive_sample(2 * one - 1, act_pkg::ACT_EXP);
        drive_sample(2 * one, act_pkg::ACT_EXP);
        drive_sample(32767, act_pkg::ACT_EXP);
        close_test("exp_sweep");

        for (int i = 0; i < random_count; i++) begin
            drive_sample(int'($signed(random_bits(16))),
                         act_pkg::act_func_e'(random_bits(1)));
        end
        close_test("random_mix");

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+bench
hw/act_pkg.sv
hw/sigmoid_segment_lut.sv
hw/exp_split_lut.sv
hw/act_combine.sv
hw/activation_unit.sv
bench/tb_activation_unit.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_activation_unit \
    -f all.f -o sim_activation_unit

./obj_dir/sim_activation_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
grep -q "Regression passed" sim.log
